// ==== Makefile ====
SIM := obj_dir/Vtb_cps15

.PHONY: all run clean

all: run

$(SIM): $(wildcard *.sv *.svh) cps15_mem.f
	verilator --binary --timing --assert -j 0 --top-module tb_cps15 \
		-f cps15_mem.f -o Vtb_cps15

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cps15_consts.svh ====
//////////////////////////////////////////////////
// SDRAM layout and download map constants for the CPS-1.5 memory side.
// Include this header wherever the region numbers are needed
//////////////////////////////////////////////////

`ifndef CPS15_CONSTS_SVH
`define CPS15_CONSTS_SVH

// Bus widths
`define CPS15_SDRAM_AW 22           // 16-bit word address
`define CPS15_IOCTL_AW 25           // Host download byte address

// Region bases inside their banks, in 16-bit words
`define CPS15_SND_OFFSET  22'h00_0000
`define CPS15_RAM_OFFSET  22'h20_0000
`define CPS15_VRAM_OFFSET 22'h30_0000
`define CPS15_GFX_OFFSET  22'h00_0000

// Bank numbers
`define CPS15_BANK_SND 2'd0         // Sound ROM, work RAM and VRAM
`define CPS15_BANK_CPU 2'd1         // Main CPU ROM
`define CPS15_BANK_GFX 2'd2         // Object and scroll tiles

// Download stream layout in bytes
// Main CPU ROM first, then sound ROM, graphics take the rest
`define CPS15_CPU_END 25'h040_0000
`define CPS15_SND_END 25'h048_0000

// Requester slots on the multiplexer
`define CPS15_NSLOTS 5

`endif

// ==== cps15_mem.f ====
+incdir+.
cps15_pkg.sv
cps15_slot.sv
cps15_sdram_arb.sv
cps15_rom_loader.sv
cps15_mem_top.sv
tb_sdram_model.sv
tb_cps15.sv

// ==== cps15_mem_top.sv ====
//////////////////////////////////////////////////
// Memory side top: five requester slots, the SDRAM arbiter and the
// download loader sharing one SDRAM controller
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module cps15_mem_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    // ROM download
    input  logic [`CPS15_IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    output logic                        prog_we,
    output cps15_pkg::prog_cmd_t        prog,
    // SDRAM controller
    input  logic                        sdram_ack,
    output logic                        sdram_req,
    output cps15_pkg::sdram_cmd_t       sdram_cmd,
    input  cps15_pkg::sdram_word_u      data_read,
    input  logic                        data_rdy,
    // Main CPU ROM
    input  logic                        main_rom_cs,
    input  logic [20:0]                 main_rom_addr,  // Word address
    output logic [15:0]                 main_rom_data,
    output logic                        main_rom_ok,
    // Work RAM and VRAM
    input  logic                        ram_cs,
    input  logic                        vram_cs,
    input  logic [16:0]                 ram_addr,
    input  logic [15:0]                 ram_din,
    input  logic [1:0]                  ram_dsn,
    input  logic                        ram_rnw,
    output logic [15:0]                 ram_data,
    output logic                        ram_ok,
    // Object and scroll graphics
    input  logic                        gfx0_cs,
    input  logic [21:0]                 gfx0_addr,
    output logic [31:0]                 gfx0_data,
    output logic                        gfx0_ok,
    input  logic                        gfx1_cs,
    input  logic [21:0]                 gfx1_addr,
    output logic [31:0]                 gfx1_data,
    output logic                        gfx1_ok,
    // Sound CPU ROM
    input  logic                        snd_cs,
    input  logic [18:0]                 snd_addr,       // Byte address
    output logic [7:0]                  snd_data,
    output logic                        snd_ok
);
    localparam logic [21:0] SND_BASE = `CPS15_SND_OFFSET << 1;

    logic [`CPS15_NSLOTS-1:0]                 slot_valid;
    logic [`CPS15_NSLOTS-1:0]                 slot_done;
    cps15_pkg::slot_req_t [`CPS15_NSLOTS-1:0] slot_req;
    cps15_pkg::sdram_word_u                   slot_rdata;
    logic [21:0] ram_full;
    logic [21:0] gfx0_full, gfx1_full, snd_full;

    assign ram_full  = (ram_cs ? `CPS15_RAM_OFFSET : `CPS15_VRAM_OFFSET) + {5'd0, ram_addr};
    assign gfx0_full = `CPS15_GFX_OFFSET + gfx0_addr;
    assign gfx1_full = `CPS15_GFX_OFFSET + gfx1_addr;
    assign snd_full  = SND_BASE + {3'd0, snd_addr};

    cps15_slot #(.DW(16)) u_main_rom (
        .clk(clk), .rst(rst), .cs(main_rom_cs), .rnw(1'b1),
        .addr({1'b0, main_rom_addr}), .din(16'd0),
        .done(slot_done[0]), .rdata(slot_rdata), .ok(main_rom_ok),
        .data(main_rom_data), .valid(slot_valid[0]), .req(slot_req[0])
    );

    cps15_slot #(.DW(16)) u_ram (
        .clk(clk), .rst(rst), .cs(ram_cs | vram_cs), .rnw(ram_rnw),
        .addr(ram_full), .din(ram_din),
        .done(slot_done[1]), .rdata(slot_rdata), .ok(ram_ok),
        .data(ram_data), .valid(slot_valid[1]), .req(slot_req[1])
    );

    cps15_slot #(.DW(32)) u_gfx0 (   // Objects
        .clk(clk), .rst(rst), .cs(gfx0_cs), .rnw(1'b1),
        .addr(gfx0_full), .din(16'd0),
        .done(slot_done[2]), .rdata(slot_rdata), .ok(gfx0_ok),
        .data(gfx0_data), .valid(slot_valid[2]), .req(slot_req[2])
    );

    cps15_slot #(.DW(32)) u_gfx1 (   // Scroll tiles
        .clk(clk), .rst(rst), .cs(gfx1_cs), .rnw(1'b1),
        .addr(gfx1_full), .din(16'd0),
        .done(slot_done[3]), .rdata(slot_rdata), .ok(gfx1_ok),
        .data(gfx1_data), .valid(slot_valid[3]), .req(slot_req[3])
    );

    cps15_slot #(.DW(8)) u_snd (
        .clk(clk), .rst(rst), .cs(snd_cs), .rnw(1'b1),
        .addr(snd_full), .din(16'd0),
        .done(slot_done[4]), .rdata(slot_rdata), .ok(snd_ok),
        .data(snd_data), .valid(slot_valid[4]), .req(slot_req[4])
    );

    // sdram_ack goes to both, the arbiter holds no request while downloading
    cps15_sdram_arb u_arb (
        .clk(clk), .rst(rst), .downloading(downloading),
        .valid(slot_valid), .req(slot_req),
        .wdata(ram_din), .wrmask(ram_dsn),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .done(slot_done), .rdata(slot_rdata),
        .sdram_req(sdram_req), .cmd(sdram_cmd)
    );

    cps15_rom_loader u_loader (
        .clk(clk), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack), .prog_we(prog_we), .prog(prog)
    );

endmodule

// ==== cps15_pkg.sv ====
//////////////////////////////////////////////////
// Shared types for the SDRAM slot multiplexer and the ROM loader.
// Referenced with cps15_pkg:: scoped names
//////////////////////////////////////////////////

`include "cps15_consts.svh"

package cps15_pkg;

    // One 32-bit SDRAM read, two consecutive 16-bit words
    // Even word in the low half, even byte in the low byte
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;     // Indexed by word address bit 0
        logic [3:0][7:0]  bytes;    // Indexed by byte address bits 1:0
    } sdram_word_u;

    // Command held toward the SDRAM controller
    typedef struct packed {
        logic [`CPS15_SDRAM_AW-1:0] addr;
        logic [1:0]                 bank;
        logic                       rnw;
        logic [1:0]                 wrmask;     // Active low byte enables
        logic [15:0]                wdata;
    } sdram_cmd_t;

    // Programming write from the download path
    typedef struct packed {
        logic [`CPS15_SDRAM_AW-1:0] addr;
        logic [7:0]                 data;
        logic [1:0]                 mask;       // Active low, one lane enabled
        logic [1:0]                 bank;
    } prog_cmd_t;

    // Slot request toward the arbiter
    typedef struct packed {
        logic [`CPS15_SDRAM_AW-1:0] addr;       // Word address with region offset
        logic                       wr;
    } slot_req_t;

endpackage

// ==== cps15_rom_loader.sv ====
//////////////////////////////////////////////////
// Turns the host download byte stream into SDRAM programming writes.
// One write per ioctl_wr, held until the controller acknowledges it
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module cps15_rom_loader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  logic [`CPS15_IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    input  logic                        sdram_ack,
    output logic                        prog_we,
    output cps15_pkg::prog_cmd_t        prog
);
    localparam int IW = `CPS15_IOCTL_AW;
    localparam int AW = `CPS15_SDRAM_AW;

    logic          is_cpu, is_snd;
    logic [IW-1:0] start;       // Region start in the byte stream
    logic [AW-1:0] offset;
    logic [1:0]    bank;
    logic [IW-1:0] rel;
    logic [IW-1:0] sum;
    logic          take;

    assign is_cpu = ioctl_addr < `CPS15_CPU_END;
    assign is_snd = !is_cpu && ioctl_addr < `CPS15_SND_END;

    always_comb begin
        if (is_cpu) begin
            start  = '0;
            offset = '0;
            bank   = `CPS15_BANK_CPU;
        end else if (is_snd) begin
            start  = `CPS15_CPU_END;
            offset = `CPS15_SND_OFFSET;
            bank   = `CPS15_BANK_SND;
        end else begin
            start  = `CPS15_SND_END;
            offset = `CPS15_GFX_OFFSET;
            bank   = `CPS15_BANK_GFX;
        end
    end

    // Offset is in words, so it joins the byte address shifted up
    assign rel  = ioctl_addr - start;
    assign sum  = rel + IW'({offset, 1'b0});
    assign take = downloading && ioctl_wr && !prog_we;  // Busy drops the byte

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else if (prog_we) begin
            if (sdram_ack) prog_we <= 1'b0;
        end else if (take) begin
            prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prog.addr <= sum[AW:1];
            prog.data <= ioctl_data;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte goes high
            prog.bank <= bank;
        end
    end

    a_we_held: assert property (@(posedge clk) disable iff (rst)
        prog_we && !sdram_ack |=> prog_we);

endmodule

// ==== cps15_sdram_arb.sv ====
//////////////////////////////////////////////////
// Fixed-priority arbiter between the slots and the SDRAM controller.
// Slot 0 wins, one transaction outstanding at a time
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module cps15_sdram_arb (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        downloading,
    input  logic [`CPS15_NSLOTS-1:0]                    valid,
    input  cps15_pkg::slot_req_t [`CPS15_NSLOTS-1:0]    req,
    input  logic [15:0]                                 wdata,
    input  logic [1:0]                                  wrmask,
    input  logic                                        sdram_ack,
    input  logic                                        data_rdy,
    input  cps15_pkg::sdram_word_u                      data_read,
    output logic [`CPS15_NSLOTS-1:0]                    done,
    output cps15_pkg::sdram_word_u                      rdata,
    output logic                                        sdram_req,
    output cps15_pkg::sdram_cmd_t                       cmd
);
    localparam int SW = $clog2(`CPS15_NSLOTS);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;   // Request out, waiting for sdram_ack
    localparam logic [1:0] ST_DATA = 2'd2;   // Waiting for data_rdy

    logic [1:0]               state;
    logic [SW-1:0]            sel;
    logic [SW-1:0]            pick;
    logic [`CPS15_NSLOTS-1:0] avail;
    logic                     grant;

    // The slot served last cycle still shows valid for one more cycle
    assign avail = valid & ~done;
    assign grant = state == ST_IDLE && |avail && !downloading;

    // Lowest index has the highest priority
    always_comb begin
        pick = '0;
        for (int i = `CPS15_NSLOTS - 1; i >= 0; i--) begin
            if (avail[i]) pick = SW'(i);
        end
    end

    function automatic logic [1:0] slot_bank(input logic [SW-1:0] idx);
        case (idx)
            0:       slot_bank = `CPS15_BANK_CPU;
            2, 3:    slot_bank = `CPS15_BANK_GFX;   // Object and scroll tiles
            default: slot_bank = `CPS15_BANK_SND;   // RAM and VRAM live here too
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            done      <= '0;
        end else begin
            done <= '0;
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        sdram_req <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin     // Also closes a write
                        done[sel] <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command and read word
    always_ff @(posedge clk) begin
        if (grant) begin
            sel <= pick;
            cmd <= '{
                addr:   req[pick].addr,
                bank:   slot_bank(pick),
                rnw:    ~req[pick].wr,
                wrmask: req[pick].wr ? wrmask : 2'b11,
                wdata:  wdata
            };
        end
        if (state == ST_DATA && data_rdy && cmd.rnw) begin
            rdata <= data_read;
        end
    end

    a_no_req_dwnld: assert property (@(posedge clk) disable iff (rst)
        $rose(sdram_req) |-> !$past(downloading));

    a_done_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(done));

endmodule

// ==== cps15_slot.sv ====
//////////////////////////////////////////////////
// Request holder for one SDRAM requester with a one-entry read cache.
// DW selects the returned lane: 8, 16 or 32 bits
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module cps15_slot #(
    parameter int DW = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cs,
    input  logic                        rnw,
    input  logic [`CPS15_SDRAM_AW-1:0]  addr,   // Byte address when DW is 8
    input  logic [15:0]                 din,
    input  logic                        done,
    input  cps15_pkg::sdram_word_u      rdata,
    output logic                        ok,
    output logic [DW-1:0]               data,
    output logic                        valid,
    output cps15_pkg::slot_req_t        req
);
    localparam int AW = `CPS15_SDRAM_AW;

    logic [AW-1:0] pend_addr;   // Address in flight or last served
    logic          pend_wr;
    logic [AW-1:0] cache_addr;
    logic          cache_vld;
    logic          wr_done;
    logic [AW-1:0] sdram_addr;
    logic [DW-1:0] lane;
    logic          hit, wr_hit, done_match, start;

    assign hit        = cache_vld && rnw && addr == cache_addr;
    assign wr_hit     = wr_done && !rnw && addr == pend_addr;
    assign done_match = addr == pend_addr && rnw == !pend_wr;
    assign start      = cs && !valid && !hit && !wr_hit;

    // Reads go out 32-bit aligned, the lane comes from the low bits
    generate
        if (DW == 32) begin : g_word
            assign lane       = rdata.word;
            assign sdram_addr = {pend_addr[AW-1:1], 1'b0};
        end else if (DW == 16) begin : g_half
            assign lane       = rdata.half[pend_addr[0]];
            assign sdram_addr = pend_wr ? pend_addr : {pend_addr[AW-1:1], 1'b0};
        end else begin : g_byte
            assign lane       = rdata.bytes[pend_addr[1:0]];
            assign sdram_addr = {1'b0, pend_addr[AW-1:2], 1'b0};
        end
    endgenerate

    assign req = '{addr: sdram_addr, wr: pend_wr};

    always_ff @(posedge clk) begin
        if (rst) begin
            ok        <= 1'b0;
            valid     <= 1'b0;
            cache_vld <= 1'b0;
            wr_done   <= 1'b0;
        end else begin
            ok <= cs && (done ? done_match : (hit || wr_hit));
            if (start) begin
                valid   <= 1'b1;
                wr_done <= 1'b0;
            end else if (done) begin
                valid     <= 1'b0;
                wr_done   <= pend_wr;
                cache_vld <= !pend_wr;  // A write drops the cached read
            end
            if (!cs) wr_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pend_addr <= addr;
            pend_wr   <= !rnw;
        end
        if (done) begin
            if (pend_wr) begin
                data <= DW'(din);   // Write echo
            end else begin
                data       <= lane;
                cache_addr <= pend_addr;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        valid && !done |=> valid && $stable(req));

endmodule

// ==== tb_cps15.sv ====
//////////////////////////////////////////////////
// Testbench for the memory side top covering slot reads and writes,
// cache hits, concurrent requests and the download path
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module tb_cps15;
    logic clk, rst, downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr, sdram_ack, sdram_req, data_rdy, prog_we;
    cps15_pkg::prog_cmd_t   prog;
    cps15_pkg::sdram_cmd_t  sdram_cmd;
    cps15_pkg::sdram_word_u data_read;
    logic        main_rom_cs, main_rom_ok;
    logic [20:0] main_rom_addr;
    logic [15:0] main_rom_data;
    logic        ram_cs, vram_cs, ram_rnw, ram_ok;
    logic [16:0] ram_addr;
    logic [15:0] ram_din, ram_data;
    logic [1:0]  ram_dsn;
    logic        gfx0_cs, gfx0_ok, gfx1_cs, gfx1_ok, snd_cs, snd_ok;
    logic [21:0] gfx0_addr, gfx1_addr;
    logic [31:0] gfx0_data, gfx1_data;
    logic [18:0] snd_addr;
    logic [7:0]  snd_data;

    integer      seed;
    int          errors, checks, tests;
    logic        vram_sel;                  // RAM slot accesses go through vram_cs
    logic [15:0] shadow [logic [23:0]];     // Words written through the RAM slot

    cps15_mem_top dut (.*);

    tb_sdram_model u_sdram (
        .clk(clk), .rst(rst), .sdram_req(sdram_req), .cmd(sdram_cmd),
        .prog_we(prog_we), .prog(prog), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    always #50 clk = ~clk;

    // Expected 16-bit word at a bank and word address
    function automatic logic [15:0] ref_word(input logic [1:0] bank, input logic [21:0] a);
        if (shadow.exists({bank, a})) return shadow[{bank, a}];
        return a[15:0] ^ {a[21:16], bank, 8'ha5};
    endfunction

    function automatic logic [21:0] ram_word(input logic vram);
        return (vram ? `CPS15_VRAM_OFFSET : `CPS15_RAM_OFFSET) + 22'(ram_addr);
    endfunction

    function automatic logic [31:0] gfx_ref(input logic [21:0] a);
        logic [21:0] w;
        w = `CPS15_GFX_OFFSET + a;
        return {ref_word(`CPS15_BANK_GFX, {w[21:1], 1'b1}),
                ref_word(`CPS15_BANK_GFX, {w[21:1], 1'b0})};
    endfunction

    function automatic logic [7:0] snd_ref(input logic [18:0] a);
        logic [21:0] b;
        logic [15:0] w;
        b = 22'(`CPS15_SND_OFFSET << 1) + 22'(a);   // Byte address
        w = ref_word(`CPS15_BANK_SND, {1'b0, b[21:1]});
        return b[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic cps15_pkg::prog_cmd_t prog_ref(input logic [24:0] a, input logic [7:0] d);
        cps15_pkg::prog_cmd_t p;
        logic [24:0] rel;
        if (a < `CPS15_CPU_END) begin
            rel    = a;
            p.bank = `CPS15_BANK_CPU;
        end else if (a < `CPS15_SND_END) begin
            rel    = a - `CPS15_CPU_END + 25'({`CPS15_SND_OFFSET, 1'b0});
            p.bank = `CPS15_BANK_SND;
        end else begin
            rel    = a - `CPS15_SND_END + 25'({`CPS15_GFX_OFFSET, 1'b0});
            p.bank = `CPS15_BANK_GFX;
        end
        p.addr       = rel[22:1];
        p.data       = d;
        p.mask       = 2'b11;
        p.mask[a[0]] = 1'b0;                // Only the lane of this byte enabled
        return p;
    endfunction

    task automatic check16(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check32(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check8(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_prog(input cps15_pkg::prog_cmd_t got, input cps15_pkg::prog_cmd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: prog got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic set_cs(input int s, input logic v);
        case (s)
            0: main_rom_cs = v;
            1: begin
                if (vram_sel) begin
                    vram_cs = v;
                end else begin
                    ram_cs = v;
                end
            end
            2: gfx0_cs     = v;
            3: gfx1_cs     = v;
            default: snd_cs = v;
        endcase
    endtask

    function automatic logic slot_ok(input int s);
        case (s)
            0: return main_rom_ok;
            1: return ram_ok;
            2: return gfx0_ok;
            3: return gfx1_ok;
            default: return snd_ok;
        endcase
    endfunction

    // Counts falling edges until ok or 200 of them
    task automatic wait_ok(input int s, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!slot_ok(s) && cycles < 200);
        if (!slot_ok(s)) begin
            errors++;
            $display("Slot %0d never returned ok at %0t", s, $time);
        end
    endtask

    task automatic check_slot(input int s);
        case (s)
            0: check16("main rom", main_rom_data,
                       ref_word(`CPS15_BANK_CPU, {1'b0, main_rom_addr}));
            1: check16("ram", ram_data, ref_word(`CPS15_BANK_SND, ram_word(vram_sel)));
            2: check32("gfx0", gfx0_data, gfx_ref(gfx0_addr));
            3: check32("gfx1", gfx1_data, gfx_ref(gfx1_addr));
            default: check8("sound", snd_data, snd_ref(snd_addr));
        endcase
    endtask

    task automatic access(input int s);
        int n;
        set_cs(s, 1'b1);
        wait_ok(s, n);
        if (ram_rnw) check_slot(s);
        set_cs(s, 1'b0);
        vram_sel = 1'b0;
        @(negedge clk);
    endtask

    task automatic randomize_addr();
        main_rom_addr = 21'($random(seed));
        ram_addr      = 17'($random(seed));
        gfx0_addr     = 22'($random(seed));
        gfx1_addr     = 22'($random(seed));
        snd_addr      = 19'($random(seed));
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    always @(posedge clk) begin
        if (!rst && downloading && sdram_req) begin
            errors++;
            $display("SDRAM request raised during download at %0t", $time);
        end
    end

    initial begin
        int e, n;
        logic [15:0] old;
        logic [24:0] dl_addr [6];
        seed        = 43092;
        clk         = 0;
        rst         = 1;
        downloading = 0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 0;
        main_rom_cs = 0;
        ram_cs      = 0;
        vram_cs     = 0;
        vram_sel    = 0;
        gfx0_cs     = 0;
        gfx1_cs     = 0;
        snd_cs      = 0;
        ram_rnw     = 1;
        ram_din     = '0;
        ram_dsn     = 2'b11;
        randomize_addr();
        repeat (5) @(negedge clk);
        rst = 0;
        @(negedge clk);

        e = errors;
        repeat (8) begin
            randomize_addr();
            access(0);
            access(2);
            access(3);
            access(4);
        end
        finish_test("random rom reads", e);

        e = errors;
        for (int k = 0; k < 3; k++) begin
            randomize_addr();
            ram_dsn = 2'(k);                // 00, 01, 10
            ram_din = 16'($random(seed));
            old = ref_word(`CPS15_BANK_SND, ram_word(1'b0));
            shadow[{`CPS15_BANK_SND, ram_word(1'b0)}] =
                {ram_dsn[1] ? old[15:8] : ram_din[15:8], ram_dsn[0] ? old[7:0] : ram_din[7:0]};
            ram_rnw = 0;
            access(1);
            ram_rnw = 1;
            access(1);
            vram_sel = 1;                   // Same address in the VRAM region
            access(1);
        end
        finish_test("ram write and vram read", e);

        e = errors;
        for (int s = 0; s < 5; s += 2) begin
            access(s);
            set_cs(s, 1'b1);
            wait_ok(s, n);
            if (n != 1) begin
                errors++;
                $display("Repeated read on slot %0d took %0d cycles", s, n);
            end
            check_slot(s);
            set_cs(s, 1'b0);
            @(negedge clk);
        end
        finish_test("cache hit", e);

        e = errors;
        repeat (4) begin
            randomize_addr();
            for (int s = 0; s < 5; s++) set_cs(s, 1'b1);
            for (int s = 0; s < 5; s++) wait_ok(s, n);
            for (int s = 0; s < 5; s++) check_slot(s);
            for (int s = 0; s < 5; s++) set_cs(s, 1'b0);
            @(negedge clk);
        end
        finish_test("all slots at once", e);

        e = errors;
        dl_addr = '{25'h000011, 25'h000024, `CPS15_CPU_END + 25'd5,
                    `CPS15_CPU_END + 25'h100, `CPS15_SND_END + 25'd3,
                    `CPS15_SND_END + 25'h12346};
        randomize_addr();                   // New main ROM address misses the cache
        downloading = 1;
        main_rom_cs = 1;                    // Held off by the download
        @(negedge clk);
        foreach (dl_addr[i]) begin
            ioctl_addr = dl_addr[i];
            ioctl_data = 8'($random(seed));
            ioctl_wr   = 1;
            @(negedge clk);
            ioctl_wr = 0;
            if (!prog_we) begin
                errors++;
                $display("No programming write for byte at %h", dl_addr[i]);
            end
            check_prog(prog, prog_ref(dl_addr[i], ioctl_data));
            n = 0;
            while (prog_we && n < 50) begin
                @(negedge clk);
                n++;
            end
            if (prog_we) begin
                errors++;
                $display("Programming write at %h was never acknowledged", dl_addr[i]);
            end
        end
        downloading = 0;
        wait_ok(0, n);                      // Blocked read goes out afterwards
        check_slot(0);
        main_rom_cs = 0;
        @(negedge clk);
        finish_test("download", e);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb_sdram_model.sv ====
//////////////////////////////////////////////////
// Behavioral SDRAM controller for the testbench: random latency,
// a fixed read pattern and stored writes per bank and word
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cps15_consts.svh"

module tb_sdram_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sdram_req,
    input  cps15_pkg::sdram_cmd_t   cmd,
    input  logic                    prog_we,
    input  cps15_pkg::prog_cmd_t    prog,
    output logic                    sdram_ack,
    output logic                    data_rdy,
    output cps15_pkg::sdram_word_u  data_read
);
    integer                seed;
    int                    wait_cnt;
    int                    phase;       // 0 idle, 1 ack, 2 data, 3 gap
    logic                  is_prog;
    cps15_pkg::sdram_cmd_t held;
    logic [15:0]           mem [logic [23:0]];

    // Unwritten words read back a pattern of bank and address
    function automatic logic [15:0] read16(input logic [1:0] bank, input logic [21:0] a);
        if (mem.exists({bank, a})) return mem[{bank, a}];
        return a[15:0] ^ {a[21:16], bank, 8'ha5};
    endfunction

    initial begin
        seed      = 43092;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
    end

    always @(posedge clk) begin
        logic [15:0] w;
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (rst) begin
            phase    = 0;
            wait_cnt = 0;
        end else if (wait_cnt > 0) begin
            wait_cnt--;
        end else begin
            case (phase)
                0: if (prog_we || sdram_req) begin
                    is_prog  = prog_we;
                    held     = cmd;
                    wait_cnt = $random(seed) & 3;
                    phase    = 1;
                end
                1: begin
                    sdram_ack <= 1'b1;
                    if (is_prog) begin
                        w = read16(prog.bank, prog.addr);
                        if (!prog.mask[0]) w[7:0] = prog.data;
                        if (!prog.mask[1]) w[15:8] = prog.data;
                        mem[{prog.bank, prog.addr}] = w;
                        phase = 3;
                    end else begin
                        wait_cnt = $random(seed) & 3;
                        phase    = 2;
                    end
                end
                2: begin
                    data_rdy <= 1'b1;
                    if (held.rnw) begin
                        data_read <= {read16(held.bank, {held.addr[21:1], 1'b1}),
                                      read16(held.bank, {held.addr[21:1], 1'b0})};
                    end else begin
                        w = read16(held.bank, held.addr);
                        if (!held.wrmask[0]) w[7:0] = held.wdata[7:0];
                        if (!held.wrmask[1]) w[15:8] = held.wdata[15:8];
                        mem[{held.bank, held.addr}] = w;
                    end
                    phase = 3;
                end
                default: phase = 0;     // Lets req or prog_we drop first
            endcase
        end
    end

endmodule
